// File: src/sample_defs.svh
`ifndef SAMPLE_DEFS_SVH
`define SAMPLE_DEFS_SVH

// Bits per sample
`define SAMPLE_WIDTH 32

// Samples per frame, an even power of two
`define FRAME_SAMPLES 8

`endif

// File: src/sample_pkg.sv
`include "sample_defs.svh"

package sample_pkg;

  typedef logic [`SAMPLE_WIDTH-1:0] sample_t;

  // Counts 0 up to FRAME_SAMPLES inclusive
  typedef logic [$clog2(`FRAME_SAMPLES + 1)-1:0] count_t;

  typedef enum logic {
    COLLECT,
    HOLD
  } deser_state_t;

endpackage

// File: src/deserializer.sv
`timescale 1ns/100ps
`include "sample_defs.svh"

module deserializer #(
  parameter int N_SAMPLES = `FRAME_SAMPLES
) (
  input  logic                clk,
  input  logic                reset,

  input  logic                recv_val,
  output logic                recv_rdy,
  input  sample_pkg::sample_t recv_msg,

  output logic                send_val,
  input  logic                send_rdy,
  output sample_pkg::sample_t send_msg [N_SAMPLES-1:0]
);

  generate
    if (N_SAMPLES == 1) begin : g_bypass
      // Single sample frame, nothing to gather
      assign recv_rdy    = send_rdy;
      assign send_val    = recv_val;
      assign send_msg[0] = recv_msg;
    end else begin : g_frame
      logic [N_SAMPLES-1:0] en_sel;

      deserializer_control #(
        .N_SAMPLES(N_SAMPLES)
      ) control_i (
        .clk     (clk),
        .reset   (reset),
        .recv_val(recv_val),
        .send_rdy(send_rdy),
        .send_val(send_val),
        .recv_rdy(recv_rdy),
        .en_sel  (en_sel)
      );

      // One slot register per sample
      for (genvar i = 0; i < N_SAMPLES; i++) begin : g_slot
        always_ff @(posedge clk) begin
          if (en_sel[i]) begin
            send_msg[i] <= recv_msg;
          end
        end
      end
    end
  endgenerate

endmodule

module deserializer_control #(
  parameter int N_SAMPLES = `FRAME_SAMPLES
) (
  input  logic                 clk,
  input  logic                 reset,

  input  logic                 recv_val,
  input  logic                 send_rdy,

  output logic                 send_val,
  output logic                 recv_rdy,

  output logic [N_SAMPLES-1:0] en_sel
);
  import sample_pkg::*;

  deser_state_t state;
  deser_state_t state_next;
  count_t       count;
  count_t       count_next;
  logic         accept;

  assign accept = recv_val && recv_rdy;

  // Count decoded to the slot being written
  assign en_sel = accept ? (N_SAMPLES'(1) << count) : '0;

  always_comb begin
    state_next = state;
    count_next = count;
    recv_rdy   = 1'b0;
    send_val   = 1'b0;
    case (state)
      COLLECT: begin
        recv_rdy = 1'b1;
        if (recv_val) begin
          count_next = count + 1'b1;
          if (count_next == count_t'(N_SAMPLES)) begin
            state_next = HOLD;  // Frame complete
          end
        end
      end
      HOLD: begin
        send_val = 1'b1;
        if (send_rdy) begin
          state_next = COLLECT;
          count_next = '0;
        end
      end
      default: begin
        state_next = COLLECT;
        count_next = '0;
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= COLLECT;
      count <= '0;
    end else begin
      state <= state_next;
      count <= count_next;
    end
  end

endmodule

// File: src/butterfly_stage.sv
`timescale 1ns/100ps
`include "sample_defs.svh"

module butterfly_stage (
  input  logic                clk,
  input  logic                reset,

  input  logic                in_val,
  output logic                in_rdy,
  input  sample_pkg::sample_t in_frame [`FRAME_SAMPLES-1:0],

  output logic                out_val,
  input  logic                out_rdy,
  output sample_pkg::sample_t out_frame [`FRAME_SAMPLES-1:0]
);
  import sample_pkg::*;

  localparam int HALF = `FRAME_SAMPLES / 2;

  sample_t frame_q [`FRAME_SAMPLES-1:0];
  logic    full;
  logic    accept;

  // Empty, or the held frame leaves this cycle
  assign in_rdy = !full || out_rdy;
  assign accept = in_val && in_rdy;

  always_ff @(posedge clk) begin
    if (reset) begin
      full <= 1'b0;
    end else if (accept) begin
      full <= 1'b1;
    end else if (out_rdy) begin
      full <= 1'b0;
    end
  end

  // Sums in the lower half, differences in the upper half
  always_ff @(posedge clk) begin
    if (accept) begin
      for (int i = 0; i < HALF; i++) begin
        frame_q[i]        <= in_frame[i] + in_frame[i+HALF];  // Wraps at sample width
        frame_q[i + HALF] <= in_frame[i] - in_frame[i+HALF];
      end
    end
  end

  assign out_val   = full;
  assign out_frame = frame_q;

endmodule

// File: src/serializer.sv
`timescale 1ns/100ps
`include "sample_defs.svh"

module serializer #(
  parameter int N_SAMPLES = `FRAME_SAMPLES
) (
  input  logic                clk,
  input  logic                reset,

  input  logic                recv_val,
  output logic                recv_rdy,
  input  sample_pkg::sample_t recv_msg [N_SAMPLES-1:0],

  output logic                send_val,
  input  logic                send_rdy,
  output sample_pkg::sample_t send_msg
);
  import sample_pkg::*;

  // Index bits into the buffer, at least one
  localparam int IDX_W = (N_SAMPLES > 1) ? $clog2(N_SAMPLES) : 1;

  sample_t frame_buf [N_SAMPLES-1:0];
  count_t  idx;
  count_t  idx_next;
  logic    busy;
  logic    load;

  assign recv_rdy = !busy;
  assign load     = recv_val && !busy;
  assign send_val = busy;
  assign send_msg = frame_buf[idx[IDX_W-1:0]];
  assign idx_next = idx + 1'b1;

  always_ff @(posedge clk) begin
    if (load) begin
      frame_buf <= recv_msg;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      busy <= 1'b0;
      idx  <= '0;
    end else if (load) begin
      busy <= 1'b1;
      idx  <= '0;
    end else if (busy && send_rdy) begin
      if (idx_next == count_t'(N_SAMPLES)) begin
        busy <= 1'b0;  // Last sample taken
        idx  <= '0;
      end else begin
        idx <= idx_next;
      end
    end
  end

endmodule

// File: src/sample_frame_top.sv
`timescale 1ns/100ps
`include "sample_defs.svh"

module sample_frame_top (
  input  logic                clk,
  input  logic                reset,

  input  logic                in_val,
  output logic                in_rdy,
  input  sample_pkg::sample_t in_sample,

  output logic                out_val,
  input  logic                out_rdy,
  output sample_pkg::sample_t out_sample
);
  import sample_pkg::*;

  logic    deser_val;
  logic    deser_rdy;
  sample_t deser_frame [`FRAME_SAMPLES-1:0];

  logic    bfly_val;
  logic    bfly_rdy;
  sample_t bfly_frame [`FRAME_SAMPLES-1:0];

  deserializer #(
    .N_SAMPLES(`FRAME_SAMPLES)
  ) deser_i (
    .clk     (clk),
    .reset   (reset),
    .recv_val(in_val),
    .recv_rdy(in_rdy),
    .recv_msg(in_sample),
    .send_val(deser_val),
    .send_rdy(deser_rdy),
    .send_msg(deser_frame)
  );

  butterfly_stage bfly_i (
    .clk      (clk),
    .reset    (reset),
    .in_val   (deser_val),
    .in_rdy   (deser_rdy),
    .in_frame (deser_frame),
    .out_val  (bfly_val),
    .out_rdy  (bfly_rdy),
    .out_frame(bfly_frame)
  );

  serializer #(
    .N_SAMPLES(`FRAME_SAMPLES)
  ) ser_i (
    .clk     (clk),
    .reset   (reset),
    .recv_val(bfly_val),
    .recv_rdy(bfly_rdy),
    .recv_msg(bfly_frame),
    .send_val(out_val),
    .send_rdy(out_rdy),
    .send_msg(out_sample)
  );

endmodule

// File: testbench/sample_frame_properties.sv
`timescale 1ns/100ps

module sample_frame_properties (
  input logic                clk,
  input logic                reset,
  input logic                in_rdy,
  input logic                out_val,
  input logic                out_rdy,
  input sample_pkg::sample_t out_sample
);

  // Stalled output holds valid and data
  out_stable_a: assert property (
    @(posedge clk) disable iff (reset)
    out_val && !out_rdy |=> out_val && $stable(out_sample)
  ) else $error("out_val or out_sample changed while out_rdy was low");

  // Idle handshake in the first cycle out of reset
  reset_idle_a: assert property (
    @(posedge clk)
    $past(reset) && !reset |-> in_rdy && !out_val
  ) else $error("handshake not idle in the cycle after reset");

  no_xfer_in_reset_a: assert property (
    @(posedge clk)
    reset |-> !(out_val && out_rdy)
  ) else $error("output transfer while reset was high");

endmodule

// File: testbench/sample_frame_tb.sv
`timescale 1ns/100ps
`include "sample_defs.svh"

module sample_frame_tb;
  import sample_pkg::*;

  localparam int F              = `FRAME_SAMPLES;
  localparam int NUM_FRAMES     = 8;
  localparam int STALL_FRAME    = 3;  // First frame with random stalls
  localparam int TOTAL          = NUM_FRAMES * F;
  localparam int WORDS          = 2 * TOTAL;
  localparam int ADDR_W         = $clog2(WORDS);
  localparam int CLK_PERIOD     = 100;
  localparam int TIMEOUT_CYCLES = NUM_FRAMES * F * 16 + 100;

  logic        clk, reset;
  logic        in_val, in_rdy, out_val, out_rdy;
  sample_t     in_sample, out_sample;
  sample_t     data_mem [0:WORDS-1];
  logic [15:0] in_lfsr, out_lfsr;
  int          errors, checks;

  sample_frame_top dut_i (
    .clk(clk), .reset(reset),
    .in_val(in_val), .in_rdy(in_rdy), .in_sample(in_sample),
    .out_val(out_val), .out_rdy(out_rdy), .out_sample(out_sample)
  );

  bind sample_frame_top sample_frame_properties props_i (
    .clk(clk), .reset(reset), .in_rdy(in_rdy),
    .out_val(out_val), .out_rdy(out_rdy), .out_sample(out_sample)
  );

  always #(CLK_PERIOD / 2) clk = ~clk;

  // Fibonacci LFSR, taps 16 14 13 11
  function automatic logic [15:0] lfsr_step(input logic [15:0] state);
    return {state[14:0], state[15] ^ state[13] ^ state[12] ^ state[10]};
  endfunction

  // Record per frame holds inputs then expected outputs
  function automatic logic [ADDR_W-1:0] word_addr(input int n, input logic expected);
    return ADDR_W'((n / F) * 2 * F + (expected ? F : 0) + n % F);
  endfunction

  task automatic check_sample(input string test_name, input sample_t expected,
                              input sample_t actual);
    checks++;
    if (actual !== expected) begin
      errors++;
      $display("FAILED %s: expected %h, actual %h", test_name, expected, actual);
    end
  endtask

  task automatic check_handshake(input string test_name, input logic expected,
                                 input logic actual);
    checks++;
    if (actual !== expected) begin
      errors++;
      $display("FAILED %s: expected %b, actual %b", test_name, expected, actual);
    end
  endtask

  initial begin : watchdog
    #(TIMEOUT_CYCLES * CLK_PERIOD);
    $display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
    $display("Testbench failed");
    $finish;
  end

  initial begin : main
    errors    = 0;
    checks    = 0;
    clk       = 1'b0;
    reset     = 1'b1;
    in_val    = 1'b0;
    in_sample = '0;
    out_rdy   = 1'b0;
    in_lfsr   = 16'd18;
    out_lfsr  = 16'd18;
    for (int i = 0; i < WORDS; i++) begin
      data_mem[i] = sample_t'(32'hbad0_0000 + i);  // Marks words the file leaves unset
    end
    $readmemh("testbench/frame_input.txt", data_mem);
    if (data_mem[WORDS-1] === sample_t'(32'hbad0_0000 + WORDS - 1)) begin
      errors++;
      $display("Stimulus file frame_input.txt is missing or too short");
    end

    @(negedge clk);
    out_rdy = 1'b1;  // Sink ready while reset is still held
    repeat (2) @(negedge clk);
    reset = 1'b0;
    #1;
    check_handshake("in_rdy after reset", 1'b1, in_rdy);
    check_handshake("out_val after reset", 1'b0, out_val);

    fork
      begin : sender
        int   n;
        logic gap;
        for (n = 0; n < TOTAL; n++) begin
          @(negedge clk);
          gap = (n >= STALL_FRAME * F);
          while (gap) begin  // Random idle cycles before a sample
            in_lfsr = lfsr_step(in_lfsr);
            gap     = in_lfsr[0];
            if (gap) begin
              in_val = 1'b0;
              @(negedge clk);
            end
          end
          in_val    = 1'b1;
          in_sample = data_mem[word_addr(n, 1'b0)];
          #1;
          while (!in_rdy) begin
            @(negedge clk);
            #1;
          end
        end
        @(negedge clk);
        in_val = 1'b0;
      end
      begin : receiver
        int count;
        count = 0;
        while (count < TOTAL) begin
          @(negedge clk);
          if (count >= STALL_FRAME * F) begin
            out_lfsr = lfsr_step(out_lfsr);
            out_rdy  = out_lfsr[0];  // Random back-pressure
          end else begin
            out_rdy = 1'b1;
          end
          #1;
          if (out_val && out_rdy) begin
            check_sample($sformatf("frame %0d sample %0d", count / F, count % F),
                         data_mem[word_addr(count, 1'b1)], out_sample);
            count++;
          end
        end
      end
    join

    // Nothing extra may come out
    @(negedge clk);
    out_rdy = 1'b1;
    repeat (2 * F) begin
      @(negedge clk);
      #1;
      check_handshake("out_val idle after last frame", 1'b0, out_val);
    end
    check_handshake("in_rdy idle after last frame", 1'b1, in_rdy);

    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

endmodule

// File: testbench/frame_input.txt
// Per frame two lines of eight hex words: inputs x0..x7, then expected outputs
// x0+x4 x1+x5 x2+x6 x3+x7 x0-x4 x1-x5 x2-x6 x3-x7, all modulo 2^32
// Small counts
00000001 00000002 00000003 00000004 00000005 00000006 00000007 00000008
00000006 00000008 0000000a 0000000c fffffffc fffffffc fffffffc fffffffc
// Wrap near the maximum
ffffffff 80000000 7fffffff 00000000 00000001 80000000 00000001 ffffffff
00000000 00000000 80000000 ffffffff fffffffe 00000000 7ffffffe 00000001
// Wrap near the minimum
80000000 80000001 7fffffff fffffffe 00000001 7fffffff 80000000 fffffffe
80000001 00000000 ffffffff fffffffc 7fffffff 00000002 ffffffff 00000000
00000010 00000020 00000030 00000040 00000001 00000002 00000003 00000004
00000011 00000022 00000033 00000044 0000000f 0000001e 0000002d 0000003c
12345678 9abcdef0 0badf00d deadbeef 11111111 22222222 33333333 44444444
23456789 bcdf0112 3ee12340 22f20333 01234567 789abcce d87abcda 9a697aab
00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000
00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000
00000000 00000000 00000000 00000000 00000001 00000002 00000003 00000004
00000001 00000002 00000003 00000004 ffffffff fffffffe fffffffd fffffffc
7fffffff 7fffffff 80000000 80000000 7fffffff 80000001 80000000 7fffffff
fffffffe 00000000 00000000 ffffffff 00000000 fffffffe 00000000 00000001

// File: src.f
+incdir+src
src/sample_pkg.sv
src/deserializer.sv
src/butterfly_stage.sv
src/serializer.sv
src/sample_frame_top.sv
testbench/sample_frame_properties.sv
testbench/sample_frame_tb.sv

// File: run_sim.sh
#!/bin/sh
# Compile and run the sample frame testbench with Verilator

cd "$(dirname "$0")" || exit 1

rm -rf obj_dir
verilator --binary --assert --top-module sample_frame_tb -f src.f > build.log 2>&1
if [ $? -ne 0 ]; then
  cat build.log
  echo "ERROR: Verilator compile failed"
  exit 1
fi

./obj_dir/Vsample_frame_tb > sim.log 2>&1
sim_status=$?
cat sim.log
if [ $sim_status -ne 0 ]; then
  echo "ERROR: simulation exited with status $sim_status"
  exit 1
fi

if grep -qx "Testbench passed" sim.log; then
  exit 0
fi
echo "ERROR: pass line not found in sim.log"
exit 1
